// File: include/firCoeffs.svh
`ifndef FIR_COEFFS_SVH
`define FIR_COEFFS_SVH

// Symmetric lowpass prototype, tap 0 weights the newest sample
// All taps at +1 overrun the positive output range on purpose
localparam int numCoeffs = 48;

localparam logic signed [coeffWidth-1:0] coeffTable [numCoeffs] = '{
    // Rising half
    -1200,
    -400,
    2600,
    4600,
    7000,
    8600,
    10300,
    12000,
    13800,
    15600,
    17400,
    19100,
    20700,
    22200,
    23600,
    24800,
    25900,
    26800,
    27600,
    28200,
    28700,
    29000,
    29200,
    29300,
    // Mirror
    29300, 29200, 29000, 28700,
    28200, 27600, 26800, 25900,
    24800, 23600, 22200, 20700,
    19100, 17400, 15600, 13800,
    12000, 10300, 8600, 7000,
    4600, 2600, -400, -1200
};

`endif

// File: verilog/firPkg.sv
package firPkg;

    // Datapath widths
    localparam int coeffWidth = 16;
    localparam int accWidth = 24;

    // Filter defaults used by the top level
    localparam int defaultNumTaps = 48;
    localparam int defaultDsr = 4;
    localparam int defaultLutBits = 6;
    localparam int defaultOutWidth = 14;
    localparam int defaultOutShift = 6;

    `include "firCoeffs.svh"

    // Partial sums and adder tree nodes
    typedef logic signed [accWidth-1:0] accT;

    // Per-cycle flags from the datapath to the register block
    typedef struct packed {
        logic outValid;
        logic satEvent;
    } firStatusT;

endpackage

// File: verilog/axiLitePkg.sv
package axiLitePkg;

    localparam int axilAddrWidth = 4;
    localparam int axilDataWidth = 32;

    typedef struct packed {
        logic                       awvalid;
        logic [axilAddrWidth-1:0]   awaddr;
        logic                       wvalid;
        logic [axilDataWidth-1:0]   wdata;
        logic [axilDataWidth/8-1:0] wstrb;
        logic                       bready;
        logic                       arvalid;
        logic [axilAddrWidth-1:0]   araddr;
        logic                       rready;
    } axilReqT;

    typedef struct packed {
        logic                     awready;
        logic                     wready;
        logic                     bvalid;
        logic [1:0]               bresp;
        logic                     arready;
        logic                     rvalid;
        logic [axilDataWidth-1:0] rdata;
        logic [1:0]               rresp;
    } axilRspT;

    localparam logic [1:0] respOkay = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    // Register map
    localparam logic [axilAddrWidth-1:0] regCtrl = 4'h0;
    localparam logic [axilAddrWidth-1:0] regStatus = 4'h4;
    localparam logic [axilAddrWidth-1:0] regLastOut = 4'h8;
    localparam logic [axilAddrWidth-1:0] regOutCount = 4'hC;

endpackage

// File: verilog/sampleHistory.sv
`timescale 1ns/100ps

module sampleHistory #(
    parameter int numTaps = 48,
    parameter int dsr = 4
) (
    input  logic               clkDS,
    input  logic               rst,
    input  logic               enable,
    input  logic [dsr-1:0]     sampleWord,
    output logic [numTaps-1:0] historyBits,
    output logic               historyValid
);

    // Words needed before every tap holds a real sample
    localparam int fillWords = numTaps / dsr;
    localparam int countWidth = $clog2(fillWords + 1);

    logic [dsr-1:0]        wordReversed;
    logic [countWidth-1:0] fillCount;

    // Word arrives oldest first, history wants newest at bit 0
    always_comb begin
        for (int i = 0; i < dsr; i++) begin
            wordReversed[i] = sampleWord[dsr - 1 - i];
        end
    end

    always_ff @(posedge clkDS) begin
        if (enable) begin
            historyBits <= {historyBits[numTaps-dsr-1:0], wordReversed};
        end
    end

    // Saturating count of captured words, restarts on every disable
    always_ff @(posedge clkDS) begin
        if (rst) begin
            fillCount <= '0;
        end else if (!enable) begin
            fillCount <= '0;
        end else if (fillCount != countWidth'(fillWords)) begin
            fillCount <= fillCount + 1'b1;
        end
    end

    assign historyValid = (fillCount == countWidth'(fillWords));

endmodule

// File: verilog/partialSumLut.sv
`timescale 1ns/100ps

module partialSumLut #(
    parameter int lutBits = 6,
    parameter int baseTap = 0
) (
    input  logic               clkDS,
    input  logic [lutBits-1:0] lutAddr,
    output firPkg::accT        partialSum
);

    import firPkg::*;

    localparam int lutSize = 1 << lutBits;

    accT lutRom [lutSize];

    // Sample 1 adds the coefficient, sample 0 subtracts it
    function automatic accT entrySum(input int addr);
        accT sum;
        sum = '0;
        for (int j = 0; j < lutBits; j++) begin
            if (addr[j]) begin
                sum = sum + accT'(coeffTable[baseTap + j]);
            end else begin
                sum = sum - accT'(coeffTable[baseTap + j]);
            end
        end
        return sum;
    endfunction

    // Table contents fixed at elaboration
    for (genvar a = 0; a < lutSize; a++) begin : genEntry
        localparam accT entryValue = entrySum(a);
        assign lutRom[a] = entryValue;
    end

    always_ff @(posedge clkDS) begin
        partialSum <= lutRom[lutAddr];
    end

endmodule

// File: verilog/adderTreeScaler.sv
`timescale 1ns/100ps

module adderTreeScaler #(
    parameter int numLuts = 8,
    parameter int outWidth = 14,
    parameter int outShift = 6
) (
    input  logic                clkDS,
    input  logic                rst,
    input  firPkg::accT         partialSums [numLuts],
    input  logic                inValid,
    output logic [outWidth-1:0] out,
    output logic                valid,
    output logic                satEvent
);

    import firPkg::*;

    localparam int treeLevels = $clog2(numLuts);
    localparam int treeLeaves = 1 << treeLevels;
    localparam accT roundHalf = accT'(1) <<< (outShift - 1);
    localparam accT satMax = (accT'(1) <<< (outWidth - 1)) - accT'(1);
    localparam accT satMin = -(accT'(1) <<< (outWidth - 1));

    // Heap layout, root at 0, leaves at the top end
    accT                 treeNodes [2*treeLeaves-1];
    logic [treeLevels-1:0] validPipe;

    accT                        rounded;
    accT                        shifted;
    logic                       clampHigh;
    logic                       clampLow;
    logic signed [outWidth-1:0] clamped;
    logic [outWidth-1:0]        outNext;

    for (genvar i = 0; i < treeLeaves; i++) begin : genLeaf
        if (i < numLuts) begin : genUsed
            assign treeNodes[treeLeaves - 1 + i] = partialSums[i];
        end else begin : genPad
            assign treeNodes[treeLeaves - 1 + i] = '0;
        end
    end

    // Every internal node is one register stage
    for (genvar n = 0; n < treeLeaves - 1; n++) begin : genNode
        always_ff @(posedge clkDS) begin
            treeNodes[n] <= treeNodes[2*n + 1] + treeNodes[2*n + 2];
        end
    end

    always_ff @(posedge clkDS) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= treeLevels'({validPipe, inValid});
        end
    end

    // Round half up, then clamp to the signed output range
    always_comb begin
        rounded = treeNodes[0] + roundHalf;
        shifted = rounded >>> outShift;
        clampHigh = shifted > satMax;
        clampLow = shifted < satMin;
        if (clampHigh) begin
            clamped = satMax[outWidth-1:0];
        end else if (clampLow) begin
            clamped = satMin[outWidth-1:0];
        end else begin
            clamped = shifted[outWidth-1:0];
        end
    end

    // Offset binary
    assign outNext = {~clamped[outWidth-1], clamped[outWidth-2:0]};

    always_ff @(posedge clkDS) begin
        if (rst) begin
            out <= '0;
            valid <= 1'b0;
            satEvent <= 1'b0;
        end else begin
            valid <= validPipe[treeLevels-1];
            satEvent <= validPipe[treeLevels-1] && (clampHigh || clampLow);
            if (validPipe[treeLevels-1]) begin
                out <= outNext;
            end
        end
    end

endmodule

// File: verilog/firCsrAxil.sv
`timescale 1ns/100ps

module firCsrAxil #(
    parameter int outWidth = 14
) (
    input  logic                clkDS,
    input  logic                rst,
    input  axiLitePkg::axilReqT axilReq,
    output axiLitePkg::axilRspT axilRsp,
    input  firPkg::firStatusT   status,
    input  logic [outWidth-1:0] lastOut,
    output logic                enable
);

    import axiLitePkg::*;

    logic                     writeAccept;
    logic                     readAccept;
    logic                     writeHit;
    logic                     readHit;
    logic                     clearSat;
    logic [axilDataWidth-1:0] readMux;

    logic                     bValid;
    logic [1:0]               bResp;
    logic                     rValid;
    logic [axilDataWidth-1:0] rData;
    logic [1:0]               rResp;

    logic                     satSticky;
    logic [outWidth-1:0]      lastOutReg;
    logic [31:0]              outCount;

    // One transaction of each kind in flight
    assign writeAccept = axilReq.awvalid && axilReq.wvalid && !bValid;
    assign readAccept = axilReq.arvalid && !rValid;

    assign clearSat = writeAccept && (axilReq.awaddr == regStatus)
                      && axilReq.wstrb[0] && axilReq.wdata[1];

    always_comb begin
        case (axilReq.awaddr)
            regCtrl, regStatus, regLastOut, regOutCount: writeHit = 1'b1;
            default: writeHit = 1'b0;
        endcase
    end

    always_comb begin
        readHit = 1'b1;
        readMux = '0;
        case (axilReq.araddr)
            regCtrl: readMux = {31'b0, enable};
            regStatus: readMux = {30'b0, satSticky, status.outValid};
            regLastOut: readMux = 32'(lastOutReg);
            regOutCount: readMux = outCount;
            default: readHit = 1'b0;
        endcase
    end

    // Write channel and CTRL
    always_ff @(posedge clkDS) begin
        if (rst) begin
            bValid <= 1'b0;
            enable <= 1'b0;
        end else if (writeAccept) begin
            bValid <= 1'b1;
            if ((axilReq.awaddr == regCtrl) && axilReq.wstrb[0]) begin
                enable <= axilReq.wdata[0];
            end
        end else if (axilReq.bready) begin
            bValid <= 1'b0;
        end
    end

    always_ff @(posedge clkDS) begin
        if (writeAccept) begin
            bResp <= writeHit ? respOkay : respSlvErr;
        end
    end

    // Read channel, data held until rready
    always_ff @(posedge clkDS) begin
        if (rst) begin
            rValid <= 1'b0;
        end else if (readAccept) begin
            rValid <= 1'b1;
        end else if (axilReq.rready) begin
            rValid <= 1'b0;
        end
    end

    always_ff @(posedge clkDS) begin
        if (readAccept) begin
            rData <= readMux;
            rResp <= readHit ? respOkay : respSlvErr;
        end
    end

    // Datapath monitors, a new event wins over a clear in the same cycle
    always_ff @(posedge clkDS) begin
        if (rst) begin
            satSticky <= 1'b0;
            lastOutReg <= '0;
            outCount <= '0;
        end else begin
            satSticky <= (satSticky && !clearSat) || status.satEvent;
            if (status.outValid) begin
                lastOutReg <= lastOut;
                outCount <= outCount + 32'd1;
            end
        end
    end

    always_comb begin
        axilRsp.awready = writeAccept;
        axilRsp.wready = writeAccept;
        axilRsp.bvalid = bValid;
        axilRsp.bresp = bResp;
        axilRsp.arready = readAccept;
        axilRsp.rvalid = rValid;
        axilRsp.rdata = rData;
        axilRsp.rresp = rResp;
    end

endmodule

// File: verilog/decimFirTop.sv
`timescale 1ns/100ps

module decimFirTop #(
    parameter int numTaps = firPkg::defaultNumTaps,
    parameter int dsr = firPkg::defaultDsr,
    parameter int lutBits = firPkg::defaultLutBits,
    parameter int outWidth = firPkg::defaultOutWidth,
    parameter int outShift = firPkg::defaultOutShift
) (
    input  logic                clkDS,
    input  logic                rst,
    input  logic [dsr-1:0]      sampleWord,
    output logic [outWidth-1:0] out,
    output logic                valid,
    input  axiLitePkg::axilReqT axilReq,
    output axiLitePkg::axilRspT axilRsp
);

    import firPkg::*;

    localparam int numLuts = numTaps / lutBits;

    logic               enable;
    logic [numTaps-1:0] historyBits;
    logic               historyValid;
    logic               lutValid;
    accT                partialSums [numLuts];
    logic               satEvent;
    firStatusT          status;

    sampleHistory #(
        .numTaps(numTaps),
        .dsr(dsr)
    ) history (
        .clkDS(clkDS),
        .rst(rst),
        .enable(enable),
        .sampleWord(sampleWord),
        .historyBits(historyBits),
        .historyValid(historyValid)
    );

    // Each table covers lutBits consecutive taps
    for (genvar i = 0; i < numLuts; i++) begin : genLut
        partialSumLut #(
            .lutBits(lutBits),
            .baseTap(i * lutBits)
        ) lut (
            .clkDS(clkDS),
            .lutAddr(historyBits[i*lutBits +: lutBits]),
            .partialSum(partialSums[i])
        );
    end

    // Matches the table read latency
    always_ff @(posedge clkDS) begin
        if (rst) begin
            lutValid <= 1'b0;
        end else begin
            lutValid <= historyValid;
        end
    end

    adderTreeScaler #(
        .numLuts(numLuts),
        .outWidth(outWidth),
        .outShift(outShift)
    ) tree (
        .clkDS(clkDS),
        .rst(rst),
        .partialSums(partialSums),
        .inValid(lutValid),
        .out(out),
        .valid(valid),
        .satEvent(satEvent)
    );

    assign status = '{outValid: valid, satEvent: satEvent};

    firCsrAxil #(
        .outWidth(outWidth)
    ) csr (
        .clkDS(clkDS),
        .rst(rst),
        .axilReq(axilReq),
        .axilRsp(axilRsp),
        .status(status),
        .lastOut(out),
        .enable(enable)
    );

endmodule

// File: tb/decimFirTb.sv
`timescale 1ns/100ps

module decimFirTb;

    import firPkg::*;
    import axiLitePkg::*;

    localparam int numTaps = defaultNumTaps;
    localparam int dsr = defaultDsr;
    localparam int outWidth = defaultOutWidth;
    localparam int outShift = defaultOutShift;
    localparam int fillWords = numTaps / dsr;
    localparam int latency = 5;

    localparam int clkPeriod = 4;
    localparam int resetCycles = 16;
    localparam int randomCycles = 300;
    localparam int onesCycles = 24;
    localparam int refillCycles = 200;
    localparam int holdCycles = 6;
    // Register accesses and fill waits
    localparam int busCycles = 300;
    localparam int totalCycles = resetCycles + randomCycles + onesCycles + refillCycles
                                 + busCycles;
    localparam int marginNs = 200;

    localparam logic [31:0] lfsrSeed = 32'hf1ba_3acf;
    localparam logic [axilAddrWidth-1:0] unmappedOffset = 4'hE;
    localparam longint outMax = (longint'(1) << (outWidth - 1)) - 1;
    localparam longint outMin = -outMax - 1;
    // Largest positive value with the sign bit inverted
    localparam logic [outWidth-1:0] clampedHigh = {1'b1, {(outWidth - 1){1'b1}}};

    logic                clkDS = 1'b0;
    logic                rst = 1'b1;
    logic [dsr-1:0]      sampleWord = '0;
    logic [outWidth-1:0] out;
    logic                valid;
    axilReqT             axilReq = '0;
    axilRspT             axilRsp;

    logic                allOnes = 1'b0;
    logic [31:0]         lfsrState = lfsrSeed;

    // Reference model state
    logic [numTaps-1:0]  modelHistory = '0;
    int                  modelFill = 0;
    logic                modelEnable = 1'b0;
    logic                pipeValid [latency+1];
    logic [outWidth-1:0] pipeOut [latency+1];
    logic [outWidth-1:0] heldOut = '0;
    logic [outWidth-1:0] lastValidOut = '0;
    int                  validCount = 0;

    decimFirTop dut (
        .clkDS(clkDS),
        .rst(rst),
        .sampleWord(sampleWord),
        .out(out),
        .valid(valid),
        .axilReq(axilReq),
        .axilRsp(axilRsp)
    );

    always #(clkPeriod / 2) clkDS = ~clkDS;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic expectEqual(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected)
        else abortRun($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, expected));
    endtask

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [dsr-1:0] randomWord();
        logic [dsr-1:0] word;
        for (int i = 0; i < dsr; i++) begin
            word[i] = lfsrState[0];
            lfsrState = lfsrNext(lfsrState);
        end
        return word;
    endfunction

    // Direct form sum where sample 1 weighs +c and sample 0 weighs -c
    function automatic logic [outWidth-1:0] predictOutput(input logic [numTaps-1:0] history);
        longint              sum;
        longint              scaled;
        logic [outWidth-1:0] twos;
        sum = 0;
        for (int k = 0; k < numTaps; k++) begin
            if (history[k]) begin
                sum = sum + longint'(coeffTable[k]);
            end else begin
                sum = sum - longint'(coeffTable[k]);
            end
        end
        scaled = (sum + (longint'(1) << (outShift - 1))) >>> outShift;
        if (scaled > outMax) begin
            scaled = outMax;
        end else if (scaled < outMin) begin
            scaled = outMin;
        end
        twos = scaled[outWidth-1:0];
        return {~twos[outWidth-1], twos[outWidth-2:0]};
    endfunction

    always @(posedge clkDS) begin
        sampleWord <= allOnes ? {dsr{1'b1}} : randomWord();
    end

    // Reads pre-edge values and predicts the state after this edge
    always @(posedge clkDS) begin
        if (rst) begin
            modelFill = 0;
            modelEnable = 1'b0;
            heldOut = '0;
            validCount = 0;
            for (int k = 0; k <= latency; k++) begin
                pipeValid[k] = 1'b0;
            end
        end else begin
            expectEqual("valid", 32'(valid), 32'(pipeValid[latency]));
            expectEqual("out", 32'(out), 32'(heldOut));
            if (pipeValid[latency]) begin
                validCount++;
                lastValidOut = heldOut;
            end
            if (modelEnable) begin
                // Oldest sample of the word enters first
                for (int i = 0; i < dsr; i++) begin
                    modelHistory = {modelHistory[numTaps-2:0], sampleWord[i]};
                end
                if (modelFill < fillWords) begin
                    modelFill++;
                end
            end else begin
                modelFill = 0;
            end
            if (axilRsp.awready && axilReq.awaddr == regCtrl && axilReq.wstrb[0]) begin
                modelEnable = axilReq.wdata[0];
            end
            for (int k = latency; k > 0; k--) begin
                pipeValid[k] = pipeValid[k-1];
                pipeOut[k] = pipeOut[k-1];
            end
            pipeValid[0] = (modelFill == fillWords);
            pipeOut[0] = predictOutput(modelHistory);
            if (pipeValid[latency]) begin
                heldOut = pipeOut[latency];
            end
        end
    end

    // Bus rules
    assert property (@(posedge clkDS) disable iff (rst)
        (axilRsp.bvalid && !axilReq.bready) |=> axilRsp.bvalid)
    else abortRun("Write response dropped before bready");

    assert property (@(posedge clkDS) disable iff (rst)
        axilRsp.bvalid |-> !axilRsp.awready)
    else abortRun("Write accepted while a write response was pending");

    assert property (@(posedge clkDS) disable iff (rst)
        (axilRsp.rvalid && !axilReq.rready) |=> (axilRsp.rvalid && $stable(axilRsp.rdata)))
    else abortRun("Read response changed before rready");

    assert property (@(posedge clkDS) disable iff (rst)
        axilRsp.awready == axilRsp.wready)
    else abortRun("awready and wready differ");

    // Starts and returns on a rising edge
    task automatic axilWrite(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        axilReq.awvalid <= 1'b1;
        axilReq.awaddr <= addr;
        axilReq.wvalid <= 1'b1;
        axilReq.wdata <= data;
        axilReq.wstrb <= 4'hF;
        axilReq.bready <= 1'b1;
        do @(posedge clkDS); while (!axilRsp.awready);
        axilReq.awvalid <= 1'b0;
        axilReq.wvalid <= 1'b0;
        do @(posedge clkDS); while (!axilRsp.bvalid);
        resp = axilRsp.bresp;
        axilReq.bready <= 1'b0;
    endtask

    task automatic axilRead(input logic [3:0] addr, input int rreadyDelay,
                            output logic [31:0] data, output logic [1:0] resp);
        axilReq.arvalid <= 1'b1;
        axilReq.araddr <= addr;
        axilReq.rready <= 1'b0;
        do @(posedge clkDS); while (!axilRsp.arready);
        axilReq.arvalid <= 1'b0;
        do @(posedge clkDS); while (!axilRsp.rvalid);
        repeat (rreadyDelay) @(posedge clkDS);
        data = axilRsp.rdata;
        resp = axilRsp.rresp;
        axilReq.rready <= 1'b1;
        @(posedge clkDS);
        axilReq.rready <= 1'b0;
    endtask

    // Second write waits on the bus while the first response is held
    task automatic checkWriteStall(input int stallCycles);
        axilReq.awvalid <= 1'b1;
        axilReq.awaddr <= regLastOut;
        axilReq.wvalid <= 1'b1;
        axilReq.wdata <= '0;
        axilReq.wstrb <= 4'hF;
        axilReq.bready <= 1'b0;
        do @(posedge clkDS); while (!axilRsp.awready);
        repeat (stallCycles) begin
            @(posedge clkDS);
            expectEqual("bvalid", 32'(axilRsp.bvalid), 32'h1);
            expectEqual("awready", 32'(axilRsp.awready), 32'h0);
        end
        axilReq.bready <= 1'b1;
        do @(posedge clkDS); while (!axilRsp.awready);
        axilReq.awvalid <= 1'b0;
        axilReq.wvalid <= 1'b0;
        do @(posedge clkDS); while (!axilRsp.bvalid);
        axilReq.bready <= 1'b0;
    endtask

    task automatic waitForValid(input int maxCycles);
        int waited;
        waited = 0;
        do begin
            @(posedge clkDS);
            waited++;
        end while (!valid && waited < maxCycles);
        if (!valid) begin
            abortRun("valid did not rise after the history filled");
        end
    endtask

    initial begin
        #(totalCycles * clkPeriod + marginNs);
        abortRun("Watchdog expired before the test sequence finished");
    end

    initial begin
        logic [31:0] readData;
        logic [1:0]  readResp;
        logic [1:0]  writeResp;
        repeat (resetCycles) @(posedge clkDS);
        rst <= 1'b0;
        @(posedge clkDS);

        assert (!valid && !axilRsp.bvalid && !axilRsp.rvalid && !axilRsp.awready
                && !axilRsp.wready && !axilRsp.arready)
        else abortRun("A valid or ready signal is high after reset");
        expectEqual("out", 32'(out), 32'h0);
        axilRead(regCtrl, 0, readData, readResp);
        expectEqual("CTRL", readData, 32'h0);

        // Model checks every edge of the random stream
        axilWrite(regCtrl, 32'h1, writeResp);
        expectEqual("bresp", 32'(writeResp), 32'(respOkay));
        axilRead(regCtrl, 0, readData, readResp);
        expectEqual("CTRL", readData, 32'h1);
        waitForValid(fillWords + latency + 4);
        repeat (randomCycles) @(posedge clkDS);

        allOnes <= 1'b1;
        repeat (onesCycles) @(posedge clkDS);
        expectEqual("out", 32'(out), 32'(clampedHigh));
        allOnes <= 1'b0;
        axilRead(regStatus, 0, readData, readResp);
        expectEqual("STATUS.sat", 32'(readData[1]), 32'h1);

        // Back-pressure on both channels
        checkWriteStall(holdCycles);
        axilRead(regOutCount, holdCycles, readData, readResp);
        expectEqual("rresp", 32'(readResp), 32'(respOkay));

        axilWrite(regCtrl, 32'h0, writeResp);
        repeat (latency + 3) @(posedge clkDS);
        expectEqual("valid", 32'(valid), 32'h0);
        axilRead(regLastOut, 0, readData, readResp);
        expectEqual("LASTOUT", readData, 32'(lastValidOut));
        axilRead(regOutCount, 0, readData, readResp);
        expectEqual("OUTCOUNT", readData, 32'(validCount));
        axilRead(unmappedOffset, 0, readData, readResp);
        expectEqual("rresp", 32'(readResp), 32'(respSlvErr));
        expectEqual("rdata", readData, 32'h0);
        axilWrite(unmappedOffset, 32'h0, writeResp);
        expectEqual("bresp", 32'(writeResp), 32'(respSlvErr));

        axilWrite(regStatus, 32'h2, writeResp);
        axilRead(regStatus, 0, readData, readResp);
        expectEqual("STATUS", readData, 32'h0);

        // Refill from an empty count
        axilWrite(regCtrl, 32'h1, writeResp);
        waitForValid(fillWords + latency + 4);
        repeat (refillCycles) @(posedge clkDS);
        axilWrite(regCtrl, 32'h0, writeResp);
        repeat (latency + 3) @(posedge clkDS);
        axilRead(regOutCount, 0, readData, readResp);
        expectEqual("OUTCOUNT", readData, 32'(validCount));

        if (validCount < randomCycles + refillCycles) begin
            abortRun("Fewer valid outputs were compared than were driven");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// File: build.f
+incdir+include
verilog/firPkg.sv
verilog/axiLitePkg.sv
verilog/sampleHistory.sv
verilog/partialSumLut.sv
verilog/adderTreeScaler.sv
verilog/firCsrAxil.sv
verilog/decimFirTop.sv
tb/decimFirTb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module decimFirTb \
    || { echo "Compile failed"; exit 1; }
./obj_dir/VdecimFirTb > sim.log 2>&1 || true
cat sim.log
grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"
